/* source/lb_defines.svh */
// Bus widths, address map and reset constants; include wherever the register map is decoded
`ifndef LB_DEFINES_SVH
`define LB_DEFINES_SVH

// ----------------------------------------
// Widths
// ----------------------------------------
`define LB_AW 24
`define LB_DW 32
`define LED_CW 10
`define MIRROR_AW 5
`define RX_CAT_W 4
`define RX_CNT_W 20

// ----------------------------------------
// Address regions
// ----------------------------------------
// Top address byte, except rx stats which uses the top twelve bits
`define REGION_REGS 8'h00
`define REGION_RX_MAC 8'h03
`define REGION_RX_STATS 12'h041
// Direct writes and mirror readback share this region
`define REGION_WRITE 8'h05

// Returned for any unmapped read
`define DEAD_WORD 32'hdeadbeef

// ----------------------------------------
// Reset constants
// ----------------------------------------
`define MISC_CONFIG_DEFAULT 8'h00
`define RX_HBANK_RESET 1'b1

// Direct-write offsets, low five address bits
`define WR_LED_USER 5'd1
`define WR_LED1_DF 5'd2
`define WR_LED2_DF 5'd3
`define WR_RX_HBANK 5'd5
`define WR_MISC 5'd8
`define WR_PS_SYNC 5'd13

// Register bank offsets, low address nibble
`define RD_HELLO0 4'h0
`define RD_HELLO1 4'h1
`define RD_HELLO2 4'h2
`define RD_HELLO3 4'h3
`define RD_FAULTS 4'h4
`define RD_TX_DONE 4'h6
`define RD_RX_BUF 4'h7
`define RD_UPTIME 4'h8

`endif

/* source/lb_pkg.sv */
// Shared vector types for the local bus slave; ports refer to them as lb_pkg::name
`default_nettype none

`include "lb_defines.svh"

package lb_pkg;

	// ----------------------------------------
	// Bus
	// ----------------------------------------
	typedef logic [`LB_AW-1:0] lb_addr_t;
	typedef logic [`LB_DW-1:0] lb_data_t;

	// ----------------------------------------
	// Status values
	// ----------------------------------------
	// Receive packet category and its count
	typedef logic [`RX_CAT_W-1:0] rx_cat_t;
	typedef logic [`RX_CNT_W-1:0] rx_count_t;

	// Cross-domain faults, wraps
	typedef logic [15:0] fault_count_t;

	// Ticks of the LED counter carry
	typedef logic [31:0] uptime_t;

	// ----------------------------------------
	// Control values
	// ----------------------------------------
	typedef logic [7:0] duty_t;
	// Bits 3:0 single outputs, bits 7:4 ext_config
	typedef logic [7:0] misc_config_t;
	typedef logic [4:0] ps_sync_t;

endpackage

`default_nettype wire

/* source/status_counters.sv */
// Per-category receive packet counters and the cross-domain fault counter, read back over the bus
`default_nettype none

`include "lb_defines.svh"

module status_counters (
	input wire clk,
	input wire rst_n,
	input wire xdomain_fault,
	input wire rx_category_s,
	input wire lb_pkg::rx_cat_t rx_category,
	input wire lb_pkg::rx_cat_t count_sel,
	output lb_pkg::fault_count_t fault_count,
	output lb_pkg::rx_count_t rx_count
);

	import lb_pkg::*;

	localparam int N_CAT = 1 << `RX_CAT_W;

	// One counter per packet category
	rx_count_t cat_cnt [N_CAT];
	fault_count_t fault_cnt;

	// ----------------------------------------
	// Category counters
	// ----------------------------------------
	// Only the addressed counter moves, all wrap
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < N_CAT; i++) begin
				cat_cnt[i] <= '0;
			end
		end else if (rx_category_s) begin
			cat_cnt[rx_category] <= cat_cnt[rx_category] + 1'b1;
		end
	end

	// ----------------------------------------
	// Fault counter
	// ----------------------------------------
	// Counts every cycle the fault flag is high
	// Expect a burst at startup while clock trees settle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fault_cnt <= '0;
		end else if (xdomain_fault) begin
			fault_cnt <= fault_cnt + 1'b1;
		end
	end

	// Readback
	// Combinational select, the read pipe registers it
	assign rx_count = cat_cnt[count_sel];
	assign fault_count = fault_cnt;

endmodule

`default_nettype wire

/* source/led_blink.sv */
// PWM drive for the two board LEDs plus the uptime counter fed by the LED cycle carry
`default_nettype none

`include "lb_defines.svh"

module led_blink (
	input wire clk,
	input wire rst_n,
	input wire lb_pkg::duty_t led1_df,
	input wire lb_pkg::duty_t led2_df,
	output logic led1,
	output logic led2,
	output lb_pkg::uptime_t uptime
);

	// Free-running PWM cycle position
	logic [`LED_CW-1:0] led_cc;
	// Carry out of led_cc, one cycle per wrap
	logic led_tick;

	// ----------------------------------------
	// Cycle counter
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led_cc <= '0;
			led_tick <= 1'b0;
		end else begin
			{led_tick, led_cc} <= led_cc + 1'b1;
		end
	end

	// ----------------------------------------
	// PWM compare
	// ----------------------------------------
	// Duty factor scaled by four to span the counter
	// High for 4*df cycles out of every wrap
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= led_cc < {led1_df, 2'b00};
			led2 <= led_cc < {led2_df, 2'b00};
		end
	end

	// Uptime
	// One tick per LED counter wrap
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			uptime <= '0;
		end else if (led_tick) begin
			uptime <= uptime + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/mirror_dpram.sv */
// Simple dual-port RAM that keeps a copy of each direct write for bus readback
`default_nettype none

module mirror_dpram #(
	parameter int aw = 5,
	parameter int dw = 32
) (
	input wire clk,
	input wire [aw-1:0] waddr,
	input wire [dw-1:0] wdata,
	input wire wen,
	input wire [aw-1:0] raddr,
	output logic [dw-1:0] rdata
);

	// Storage, contents undefined after power-up
	logic [dw-1:0] mem [1 << aw];

	// Write port
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	// Read port
	// Registered, one cycle from raddr to rdata
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

/* source/lb_write_decode.sv */
// Direct-write decode of the local bus into the control registers and their board outputs
`default_nettype none

`include "lb_defines.svh"

module lb_write_decode (
	input wire clk,
	input wire rst_n,
	input wire lb_pkg::lb_addr_t addr,
	input wire control_strobe,
	input wire control_rd,
	input wire lb_pkg::lb_data_t data_out,
	output logic local_write,
	output lb_pkg::duty_t led1_df,
	output lb_pkg::duty_t led2_df,
	output logic [1:0] led_user_mode,
	output logic rx_mac_hbank,
	output logic cfg_d02,
	output logic mmc_int,
	output logic allow_mmc_eth_config,
	output logic zest_pwr_en,
	output logic [3:0] ext_config,
	output lb_pkg::ps_sync_t ps_sync_config
);

	import lb_pkg::*;

	misc_config_t misc_config;

	// ----------------------------------------
	// Write enable
	// ----------------------------------------
	// Write strobe inside the write region only
	// Same region reads back through the mirror
	assign local_write = control_strobe & ~control_rd &
		(addr[`LB_AW-1:`LB_AW-8] == `REGION_WRITE);

	// ----------------------------------------
	// Control registers
	// ----------------------------------------
	// Offset is the low five address bits
	// Each register takes the low bits of the bus word
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led_user_mode <= 2'b00;
			led1_df <= '0;
			led2_df <= '0;
			rx_mac_hbank <= `RX_HBANK_RESET;
			misc_config <= `MISC_CONFIG_DEFAULT;
			ps_sync_config <= '0;
		end else if (local_write) begin
			case (addr[4:0])
				`WR_LED_USER: led_user_mode <= data_out[1:0];
				`WR_LED1_DF: led1_df <= data_out[7:0];
				`WR_LED2_DF: led2_df <= data_out[7:0];
				`WR_RX_HBANK: rx_mac_hbank <= data_out[0];
				`WR_MISC: misc_config <= data_out[7:0];
				`WR_PS_SYNC: ps_sync_config <= data_out[4:0];
				// Other offsets only land in the mirror
				default: ;
			endcase
		end
	end

	// Output mapping
	// Low nibble to single board pins
	assign cfg_d02 = misc_config[0];
	assign mmc_int = misc_config[1];
	assign allow_mmc_eth_config = misc_config[2];
	assign zest_pwr_en = misc_config[3];
	// High nibble to external config
	assign ext_config = misc_config[7:4];

endmodule

`default_nettype wire

/* source/lb_read_pipe.sv */
// Two-cycle read path of the local bus: register bank select, then region decode into data_in
`default_nettype none

`include "lb_defines.svh"

module lb_read_pipe (
	input wire clk,
	input wire rst_n,
	input wire lb_pkg::lb_addr_t addr,
	input wire control_strobe,
	input wire control_rd,
	input wire lb_pkg::fault_count_t fault_count,
	input wire lb_pkg::uptime_t uptime,
	input wire lb_pkg::rx_count_t rx_count,
	input wire tx_mac_done,
	input wire [1:0] rx_mac_buf_status,
	input wire [15:0] rx_mac_data,
	input wire lb_pkg::lb_data_t mirror_word,
	output lb_pkg::lb_data_t data_in
);

	import lb_pkg::*;

	// Read strobe and its one-cycle delay
	logic do_rd;
	logic do_rd_r;

	// Stage one results
	lb_addr_t addr_r;
	lb_data_t bank_word;
	rx_count_t rx_count_r;

	// MAC status brought into clk before readback
	logic tx_mac_done_r;
	logic [1:0] rx_mac_buf_status_r;

	assign do_rd = control_strobe & control_rd;

	always_ff @(posedge clk) begin
		tx_mac_done_r <= tx_mac_done;
		rx_mac_buf_status_r <= rx_mac_buf_status;
	end

	// ----------------------------------------
	// Stage one
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			do_rd_r <= 1'b0;
		end else begin
			do_rd_r <= do_rd;
		end
	end

	// Bank word by low nibble, unused slots read 0
	always_ff @(posedge clk) begin
		if (do_rd) begin
			addr_r <= addr;
			rx_count_r <= rx_count;
			case (addr[3:0])
				`RD_HELLO0: bank_word <= "Hell";
				`RD_HELLO1: bank_word <= "o wo";
				`RD_HELLO2: bank_word <= "rld!";
				`RD_HELLO3: bank_word <= "(::)";
				`RD_FAULTS: bank_word <= lb_data_t'(fault_count);
				`RD_TX_DONE: bank_word <= lb_data_t'(tx_mac_done_r);
				`RD_RX_BUF: bank_word <= lb_data_t'(rx_mac_buf_status_r);
				`RD_UPTIME: bank_word <= uptime;
				default: bank_word <= '0;
			endcase
		end
	end

	// ----------------------------------------
	// Stage two
	// ----------------------------------------
	// Region decode on the stored address
	// data_in holds until the next read completes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_in <= '0;
		end else if (do_rd_r) begin
			if (addr_r[23:16] == `REGION_REGS && addr_r[7:4] == 4'h0) begin
				data_in <= bank_word;
			end else if (addr_r[23:16] == `REGION_RX_MAC) begin
				data_in <= lb_data_t'(rx_mac_data);
			end else if (addr_r[23:12] == `REGION_RX_STATS) begin
				data_in <= lb_data_t'(rx_count_r);
			end else if (addr_r[23:16] == `REGION_WRITE) begin
				// RAM output already follows addr_r
				data_in <= mirror_word;
			end else begin
				data_in <= `DEAD_WORD;
			end
		end
	end

endmodule

`default_nettype wire

/* source/lb_marble_slave.sv */
// Top level of the local-bus register slave; connects the bus to counters, LEDs, mirror and control
`default_nettype none

`include "lb_defines.svh"

module lb_marble_slave (
	input wire clk,
	input wire rst_n,
	// Local bus
	input wire lb_pkg::lb_addr_t addr,
	input wire control_strobe,
	input wire control_rd,
	input wire lb_pkg::lb_data_t data_out,
	output wire lb_pkg::lb_data_t data_in,
	// Status inputs
	input wire xdomain_fault,
	input wire rx_category_s,
	input wire lb_pkg::rx_cat_t rx_category,
	input wire tx_mac_done,
	input wire [15:0] rx_mac_data,
	input wire [1:0] rx_mac_buf_status,
	// Control outputs
	output wire rx_mac_hbank,
	output wire cfg_d02,
	output wire mmc_int,
	output wire allow_mmc_eth_config,
	output wire zest_pwr_en,
	output wire [3:0] ext_config,
	output wire lb_pkg::ps_sync_t ps_sync_config,
	output wire [1:0] led_user_mode,
	// PWM LEDs
	output wire led1,
	output wire led2
);

	import lb_pkg::*;

	wire local_write;
	wire fault_count_t fault_count;
	wire rx_count_t rx_count;
	wire uptime_t uptime;
	wire duty_t led1_df;
	wire duty_t led2_df;
	wire lb_data_t mirror_word;

	// ----------------------------------------
	// Status
	// ----------------------------------------
	// Count select follows the live address
	status_counters u_counters (
		.clk(clk),
		.rst_n(rst_n),
		.xdomain_fault(xdomain_fault),
		.rx_category_s(rx_category_s),
		.rx_category(rx_category),
		.count_sel(addr[`RX_CAT_W-1:0]),
		.fault_count(fault_count),
		.rx_count(rx_count)
	);

	led_blink u_leds (
		.clk(clk),
		.rst_n(rst_n),
		.led1_df(led1_df),
		.led2_df(led2_df),
		.led1(led1),
		.led2(led2),
		.uptime(uptime)
	);

	// ----------------------------------------
	// Writes
	// ----------------------------------------
	lb_write_decode u_wr (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.control_strobe(control_strobe),
		.control_rd(control_rd),
		.data_out(data_out),
		.local_write(local_write),
		.led1_df(led1_df),
		.led2_df(led2_df),
		.led_user_mode(led_user_mode),
		.rx_mac_hbank(rx_mac_hbank),
		.cfg_d02(cfg_d02),
		.mmc_int(mmc_int),
		.allow_mmc_eth_config(allow_mmc_eth_config),
		.zest_pwr_en(zest_pwr_en),
		.ext_config(ext_config),
		.ps_sync_config(ps_sync_config)
	);

	// Mirror of every direct write, same offset on both ports
	mirror_dpram #(
		.aw(`MIRROR_AW),
		.dw(`LB_DW)
	) u_mirror (
		.clk(clk),
		.waddr(addr[`MIRROR_AW-1:0]),
		.wdata(data_out),
		.wen(local_write),
		.raddr(addr[`MIRROR_AW-1:0]),
		.rdata(mirror_word)
	);

	// ----------------------------------------
	// Reads
	// ----------------------------------------
	lb_read_pipe u_rd (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.control_strobe(control_strobe),
		.control_rd(control_rd),
		.fault_count(fault_count),
		.uptime(uptime),
		.rx_count(rx_count),
		.tx_mac_done(tx_mac_done),
		.rx_mac_buf_status(rx_mac_buf_status),
		.rx_mac_data(rx_mac_data),
		.mirror_word(mirror_word),
		.data_in(data_in)
	);

endmodule

`default_nettype wire

/* verif/lb_marble_slave_chk.sv */
// Concurrent assertions on the control registers and LED drive; bound into the slave top level
`default_nettype none

module lb_marble_slave_chk (
	input wire clk,
	input wire rst_n,
	input wire local_write,
	input wire lb_pkg::duty_t led1_df,
	input wire lb_pkg::duty_t led2_df,
	input wire [1:0] led_user_mode,
	input wire rx_mac_hbank,
	input wire [3:0] misc_low,
	input wire [3:0] ext_config,
	input wire lb_pkg::ps_sync_t ps_sync_config,
	input wire led1,
	input wire led2
);

	// All control register bits side by side
	wire [31:0] ctrl_state;

	assign ctrl_state = {led_user_mode, led1_df, led2_df, rx_mac_hbank, misc_low,
		ext_config, ps_sync_config};

	// ----------------------------------------
	// Write decode
	// ----------------------------------------
	// Registers move only on the edge that takes a direct write
	reg_change_needs_write: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable(ctrl_state) |-> $past(local_write))
		else $error("Control register changed without a direct write");

	// Receive bank comes out of reset selected
	hbank_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> rx_mac_hbank)
		else $error("rx_mac_hbank not set when reset released");

	// ----------------------------------------
	// LED drive
	// ----------------------------------------
	led1_off_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(led1_df == 8'h00) |=> !led1)
		else $error("led1 high with zero duty factor");

	led2_off_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(led2_df == 8'h00) |=> !led2)
		else $error("led2 high with zero duty factor");

endmodule

bind lb_marble_slave lb_marble_slave_chk u_chk (
	.clk(clk),
	.rst_n(rst_n),
	.local_write(local_write),
	.led1_df(led1_df),
	.led2_df(led2_df),
	.led_user_mode(led_user_mode),
	.rx_mac_hbank(rx_mac_hbank),
	.misc_low({zest_pwr_en, allow_mmc_eth_config, mmc_int, cfg_d02}),
	.ext_config(ext_config),
	.ps_sync_config(ps_sync_config),
	.led1(led1),
	.led2(led2)
);

`default_nettype wire

/* verif/lb_marble_slave_tb.sv */
// Self-checking testbench for the local-bus slave; random bus traffic compared with a reference model
`default_nettype none

`include "lb_defines.svh"

module lb_marble_slave_tb;

	localparam int MAX_WAIT = 40;

	logic clk;
	logic rst_n;
	logic [23:0] addr;
	logic control_strobe;
	logic control_rd;
	logic [31:0] data_out;
	wire [31:0] data_in;
	logic xdomain_fault;
	logic rx_category_s;
	logic [3:0] rx_category;
	logic tx_mac_done;
	logic [15:0] rx_mac_data;
	logic [1:0] rx_mac_buf_status;
	wire rx_mac_hbank;
	wire cfg_d02;
	wire mmc_int;
	wire allow_mmc_eth_config;
	wire zest_pwr_en;
	wire [3:0] ext_config;
	wire [4:0] ps_sync_config;
	wire [1:0] led_user_mode;
	wire led1;
	wire led2;

	integer seed;

	// ----------------------------------------
	// Reference model state
	// ----------------------------------------
	logic [31:0] m_mirror [32];
	bit m_written [32];
	logic [1:0] m_led_user;
	logic [7:0] m_led1_df;
	logic [7:0] m_led2_df;
	logic m_hbank;
	logic [7:0] m_misc;
	logic [4:0] m_ps_sync;
	logic [19:0] m_cat [16];
	logic [15:0] m_faults;

	// Reads in flight, oldest first
	logic [31:0] exp_q [$];
	bit check_q [$];
	logic [1:0] rd_pipe;
	logic [31:0] last_rd;
	logic [31:0] mon_exp;
	bit mon_chk;

	lb_marble_slave UUT (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.control_strobe(control_strobe),
		.control_rd(control_rd),
		.data_out(data_out),
		.data_in(data_in),
		.xdomain_fault(xdomain_fault),
		.rx_category_s(rx_category_s),
		.rx_category(rx_category),
		.tx_mac_done(tx_mac_done),
		.rx_mac_data(rx_mac_data),
		.rx_mac_buf_status(rx_mac_buf_status),
		.rx_mac_hbank(rx_mac_hbank),
		.cfg_d02(cfg_d02),
		.mmc_int(mmc_int),
		.allow_mmc_eth_config(allow_mmc_eth_config),
		.zest_pwr_en(zest_pwr_en),
		.ext_config(ext_config),
		.ps_sync_config(ps_sync_config),
		.led_user_mode(led_user_mode),
		.led1(led1),
		.led2(led2)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
			report_failure("Wrong value seen, run stopped");
		end
	endtask

	// ----------------------------------------
	// Bus drivers
	// ----------------------------------------
	// Direct write also updates the model
	task automatic bus_write(input logic [23:0] a, input logic [31:0] d);
		@(posedge clk);
		addr <= a;
		data_out <= d;
		control_strobe <= 1'b1;
		control_rd <= 1'b0;
		if (a[23:16] == `REGION_WRITE) begin
			m_mirror[a[4:0]] = d;
			m_written[a[4:0]] = 1'b1;
			case (a[4:0])
				`WR_LED_USER: m_led_user = d[1:0];
				`WR_LED1_DF: m_led1_df = d[7:0];
				`WR_LED2_DF: m_led2_df = d[7:0];
				`WR_RX_HBANK: m_hbank = d[0];
				`WR_MISC: m_misc = d[7:0];
				`WR_PS_SYNC: m_ps_sync = d[4:0];
				default: ;
			endcase
		end
	endtask

	// Expected word queued for the monitor
	task automatic bus_read(input logic [23:0] a, input logic [31:0] exp, input bit chk);
		@(posedge clk);
		addr <= a;
		control_strobe <= 1'b1;
		control_rd <= 1'b1;
		exp_q.push_back(exp);
		check_q.push_back(chk);
	endtask

	task automatic bus_idle();
		@(posedge clk);
		control_strobe <= 1'b0;
		control_rd <= 1'b0;
	endtask

	task automatic wait_reads();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < MAX_WAIT) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			report_failure("Timed out waiting for outstanding reads to return");
		end
	endtask

	// Raw read, result left unchecked for the caller
	task automatic read_value(input logic [23:0] a, output logic [31:0] v);
		bus_read(a, 32'h0, 1'b0);
		bus_idle();
		wait_reads();
		v = last_rd;
	endtask

	// Read word by the address map
	function automatic logic [31:0] expected_read(input logic [23:0] a);
		logic [31:0] w;
		w = `DEAD_WORD;
		if (a[23:16] == `REGION_REGS && a[7:4] == 4'h0) begin
			case (a[3:0])
				4'h0: w = 32'h48656c6c;
				4'h1: w = 32'h6f20776f;
				4'h2: w = 32'h726c6421;
				4'h3: w = 32'h283a3a29;
				4'h4: w = {16'h0, m_faults};
				4'h6: w = {31'h0, tx_mac_done};
				4'h7: w = {30'h0, rx_mac_buf_status};
				default: w = 32'h0;
			endcase
		end else if (a[23:16] == `REGION_RX_MAC) begin
			w = {16'h0, rx_mac_data};
		end else if (a[23:12] == `REGION_RX_STATS) begin
			w = {12'h0, m_cat[a[3:0]]};
		end else if (a[23:16] == `REGION_WRITE) begin
			w = m_mirror[a[4:0]];
		end
		return w;
	endfunction

	task automatic check_outputs();
		compare("led_user_mode", 32'(led_user_mode), 32'(m_led_user));
		compare("rx_mac_hbank", 32'(rx_mac_hbank), 32'(m_hbank));
		compare("cfg_d02", 32'(cfg_d02), 32'(m_misc[0]));
		compare("mmc_int", 32'(mmc_int), 32'(m_misc[1]));
		compare("allow_mmc_eth_config", 32'(allow_mmc_eth_config), 32'(m_misc[2]));
		compare("zest_pwr_en", 32'(zest_pwr_en), 32'(m_misc[3]));
		compare("ext_config", 32'(ext_config), 32'(m_misc[7:4]));
		compare("ps_sync_config", 32'(ps_sync_config), 32'(m_ps_sync));
	endtask

	// High cycles of both LEDs over one full PWM period
	task automatic led_counts(output int c1, output int c2);
		c1 = 0;
		c2 = 0;
		repeat (1024) begin
			@(negedge clk);
			c1 += int'(led1);
			c2 += int'(led2);
		end
	endtask

	// ----------------------------------------
	// Read monitor
	// ----------------------------------------
	// Strobe seen by the DUT, two edges to data_in
	always @(posedge clk) begin
		if (!rst_n) begin
			rd_pipe <= 2'b00;
		end else begin
			rd_pipe <= {rd_pipe[0], control_strobe & control_rd};
		end
	end

	always @(negedge clk) begin
		if (rd_pipe[1]) begin
			if (exp_q.size() == 0) begin
				report_failure("Read data returned with no read outstanding");
			end else begin
				mon_exp = exp_q.pop_front();
				mon_chk = check_q.pop_front();
				last_rd = data_in;
				if (mon_chk) begin
					compare("data_in", data_in, mon_exp);
				end
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic [23:0] a;
		logic [31:0] u1;
		logic [31:0] u2;
		logic [7:0] d1;
		logic [7:0] d2;
		int c1;
		int c2;
		seed = 36;
		rst_n = 1'b0;
		addr = '0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		data_out = '0;
		xdomain_fault = 1'b0;
		rx_category_s = 1'b0;
		rx_category = '0;
		tx_mac_done = 1'b0;
		rx_mac_data = '0;
		rx_mac_buf_status = '0;
		rd_pipe = 2'b00;
		m_led_user = 2'b00;
		m_led1_df = 8'h00;
		m_led2_df = 8'h00;
		m_hbank = 1'b1;
		m_misc = `MISC_CONFIG_DEFAULT;
		m_ps_sync = 5'h00;
		m_faults = 16'h0;
		for (int i = 0; i < 32; i++) begin
			m_written[i] = 1'b0;
		end
		for (int i = 0; i < 16; i++) begin
			m_cat[i] = 20'h0;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		compare("data_in", data_in, 32'h0);
		check_outputs();

		// Identification words, then unmapped reads back to back
		for (int i = 0; i < 4; i++) begin
			bus_read(24'(i), expected_read(24'(i)), 1'b1);
		end
		for (int i = 0; i < 24; i++) begin
			r = $random(seed);
			a = r[6] ? (r[23:0] | 24'h800000) : ({8'h00, r[15:0]} | 24'h000010);
			bus_read(a, expected_read(a), 1'b1);
		end
		bus_idle();
		wait_reads();

		// Mirror traffic, writes and reads mixed with no gaps
		for (int i = 0; i < 120; i++) begin
			r = $random(seed);
			a = {`REGION_WRITE, r[18:8], r[4:0]};
			if (r[5] || !m_written[r[4:0]]) begin
				bus_write(a, $random(seed));
			end else begin
				bus_read(a, expected_read(a), 1'b1);
			end
		end
		for (int i = 0; i < 32; i++) begin
			a = {`REGION_WRITE, 11'h0, 5'(i)};
			if (m_written[i]) begin
				bus_read(a, expected_read(a), 1'b1);
			end
		end
		bus_idle();
		wait_reads();

		// Control registers inside, then outside, the write region
		bus_write({`REGION_WRITE, 11'h0, `WR_LED_USER}, $random(seed));
		bus_write({`REGION_WRITE, 11'h0, `WR_RX_HBANK}, $random(seed));
		bus_write({`REGION_WRITE, 11'h0, `WR_MISC}, $random(seed));
		bus_write({`REGION_WRITE, 11'h0, `WR_PS_SYNC}, $random(seed));
		bus_write({`REGION_WRITE, 11'h0, `WR_LED1_DF}, $random(seed));
		bus_write({`REGION_WRITE, 11'h0, `WR_LED2_DF}, $random(seed));
		bus_idle();
		@(negedge clk);
		check_outputs();
		for (int i = 0; i < 30; i++) begin
			r = $random(seed);
			a = r[23:0];
			if (a[23:16] == `REGION_WRITE) begin
				a[23:16] = 8'h06;
			end
			bus_write(a, $random(seed));
		end
		bus_idle();
		@(negedge clk);
		check_outputs();

		// Counter pulses, then idle inputs
		for (int i = 0; i < 300; i++) begin
			r = $random(seed);
			@(posedge clk);
			xdomain_fault <= r[0];
			rx_category_s <= r[1];
			rx_category <= r[5:2];
			if (r[0]) begin
				m_faults = m_faults + 16'h1;
			end
			if (r[1]) begin
				m_cat[r[5:2]] = m_cat[r[5:2]] + 20'h1;
			end
		end
		r = $random(seed);
		@(posedge clk);
		xdomain_fault <= 1'b0;
		rx_category_s <= 1'b0;
		tx_mac_done <= 1'b1;
		rx_mac_buf_status <= r[1:0];
		rx_mac_data <= r[31:16];
		repeat (4) @(posedge clk);
		bus_read(24'h000004, expected_read(24'h000004), 1'b1);
		bus_read(24'h000006, expected_read(24'h000006), 1'b1);
		bus_read(24'h000007, expected_read(24'h000007), 1'b1);
		a = {`REGION_RX_MAC, r[15:0]};
		bus_read(a, expected_read(a), 1'b1);
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			a = {`REGION_RX_STATS, r[7:0], 4'(i)};
			bus_read(a, expected_read(a), 1'b1);
		end
		bus_idle();
		wait_reads();

		// LED PWM, second pass has one LED off
		for (int pass = 0; pass < 2; pass++) begin
			r = $random(seed);
			d1 = r[7:0];
			d2 = (pass == 1) ? 8'h00 : r[15:8];
			bus_write({`REGION_WRITE, 11'h0, `WR_LED1_DF}, {24'h0, d1});
			bus_write({`REGION_WRITE, 11'h0, `WR_LED2_DF}, {24'h0, d2});
			bus_idle();
			repeat (3) @(posedge clk);
			led_counts(c1, c2);
			compare("led1 high cycles", 32'(c1), {22'h0, d1, 2'b00});
			compare("led2 high cycles", 32'(c2), {22'h0, d2, 2'b00});
		end

		// Uptime ticks once per 1024 cycles
		read_value(24'h000008, u1);
		repeat (1100) @(posedge clk);
		read_value(24'h000008, u2);
		if (u2 - u1 != 32'd1 && u2 - u1 != 32'd2) begin
			$display("Uptime advanced by %0d ticks across 1100 cycles", u2 - u1);
			report_failure("Uptime did not advance by one or two ticks");
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/lb_pkg.sv
source/status_counters.sv
source/led_blink.sv
source/mirror_dpram.sv
source/lb_write_decode.sv
source/lb_read_pipe.sv
source/lb_marble_slave.sv
verif/lb_marble_slave_chk.sv
verif/lb_marble_slave_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only if the pass message appears
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module lb_marble_slave_tb -o lb_sim \
	&& ./obj_dir/lb_sim | tee /dev/stderr | grep "Testbench passed" > /dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
